// File: logic/axil_reg_slave.sv
`include "soc_gpio_cfg.svh"

module axil_reg_slave (
    input  logic                                         clk_i,
    input  logic                                         rst_i,

    input  soc_periph_pkg::axil_aw_t                     aw_i,
    input  logic                                         awvalid_i,
    output logic                                         awready_o,
    input  soc_periph_pkg::axil_w_t                      w_i,
    input  logic                                         wvalid_i,
    output logic                                         wready_o,
    input  soc_periph_pkg::axil_aw_t                     ar_i,
    input  logic                                         arvalid_i,
    output logic                                         arready_o,

    output soc_periph_pkg::axil_b_t                      b_o,
    output logic                                         bvalid_o,
    input  logic                                         bready_i,
    output soc_periph_pkg::axil_r_t                      r_o,
    output logic                                         rvalid_o,
    input  logic                                         rready_i,

    output soc_periph_pkg::reg_req_t [`GPIO_NBANK-1:0]   bank_req_o,
    input  soc_periph_pkg::reg_rsp_t                     rsp_i
);

    import soc_periph_pkg::*;

    localparam int BANK_LSB   = $clog2(`GPIO_BANK_STRIDE);
    localparam int BANK_IDX_W = $clog2(`GPIO_NBANK);
    localparam logic [`AXI_ADDR_W-1:0] RANGE_END =
        `AXI_ADDR_W'(`GPIO_NBANK * `GPIO_BANK_STRIDE);

    logic                   pending;
    logic                   wr_accept;
    logic                   rd_accept;
    logic                   access;
    logic [`AXI_ADDR_W-1:0] sel_addr;
    logic                   in_range;
    logic [BANK_IDX_W-1:0]  bank_idx;
    logic                   rsp_ok;
    logic [1:0]             resp_code;

    logic                   bvalid_q;
    logic                   rvalid_q;
    axil_b_t                b_q;
    axil_r_t                r_q;

    ////////////////////////////////////////////////////////////
    // Handshake and arbitration
    ////////////////////////////////////////////////////////////

    // One outstanding response at a time
    assign pending   = bvalid_q | rvalid_q;

    // Write wins when both address channels show up together
    assign wr_accept = awvalid_i & wvalid_i & ~pending;
    assign awready_o = wr_accept;
    assign wready_o  = wr_accept;
    assign arready_o = arvalid_i & ~pending & ~(awvalid_i & wvalid_i);
    assign rd_accept = arvalid_i & arready_o;
    assign access    = wr_accept | rd_accept;

    ////////////////////////////////////////////////////////////
    // Address decode and bank requests
    ////////////////////////////////////////////////////////////

    assign sel_addr = wr_accept ? aw_i.addr : ar_i.addr;
    assign in_range = sel_addr < RANGE_END;
    assign bank_idx = sel_addr[BANK_LSB +: BANK_IDX_W];

    always_comb begin
        for (int k = 0; k < `GPIO_NBANK; k++) begin
            bank_req_o[k].valid  = access & in_range & (bank_idx == BANK_IDX_W'(k));
            bank_req_o[k].write  = wr_accept;
            bank_req_o[k].offset = sel_addr[REG_OFF_W-1:0];
            bank_req_o[k].wdata  = w_i.data;
        end
    end

    // Out of range never reaches a bank
    assign rsp_ok    = in_range & ~rsp_i.err;
    assign resp_code = rsp_ok ? RESP_OKAY : RESP_SLVERR;

    ////////////////////////////////////////////////////////////
    // Response channels
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (wr_accept) begin
                bvalid_q <= 1'b1;
            end else if (bready_i) begin
                bvalid_q <= 1'b0;
            end
            if (rd_accept) begin
                rvalid_q <= 1'b1;
            end else if (rready_i) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_accept) begin
            b_q.resp <= resp_code;
        end
        if (rd_accept) begin
            r_q.resp <= resp_code;
            r_q.data <= rsp_ok ? rsp_i.rdata : '0;
        end
    end

    assign bvalid_o = bvalid_q;
    assign rvalid_o = rvalid_q;
    assign b_o      = b_q;
    assign r_o      = r_q;

endmodule

// File: logic/gpio_bank.sv
`include "soc_gpio_cfg.svh"

module gpio_bank (
    input  logic                      clk_i,
    input  logic                      rst_i,

    input  soc_periph_pkg::reg_req_t  req_i,
    output soc_periph_pkg::reg_rsp_t  rsp_o,

    input  logic [`GPIO_BANK_W-1:0]   pin_i,
    output logic [`GPIO_BANK_W-1:0]   pin_o,
    output logic [`GPIO_BANK_W-1:0]   dir_o,
    output logic                      irq_o
);

    import soc_periph_pkg::*;

    localparam int PAD_W = `AXI_DATA_W - `GPIO_BANK_W;

    logic [`GPIO_BANK_W-1:0] dir_q;
    logic [`GPIO_BANK_W-1:0] out_q;
    logic [`GPIO_BANK_W-1:0] irqen_q;
    logic [`GPIO_BANK_W-1:0] status_q;

    logic [`GPIO_BANK_W-1:0] sync1_q;
    logic [`GPIO_BANK_W-1:0] sync2_q;
    logic [`GPIO_BANK_W-1:0] prev_q;
    logic [`GPIO_BANK_W-1:0] rise;

    logic                    bad_access;
    logic [`GPIO_BANK_W-1:0] rd_val;
    logic                    wr_en;

    ////////////////////////////////////////////////////////////
    // Register decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        bad_access = 1'b0;
        rd_val     = '0;
        case (req_i.offset)
            `GPIO_REG_DIR:    rd_val = dir_q;
            `GPIO_REG_OUT:    rd_val = out_q;
            `GPIO_REG_IN: begin
                rd_val     = sync2_q;
                bad_access = req_i.write;
            end
            `GPIO_REG_IRQEN:  rd_val = irqen_q;
            `GPIO_REG_STATUS: rd_val = status_q;
            default:          bad_access = 1'b1;
        endcase
    end

    // Unselected bank drives zero so the merge can OR
    assign rsp_o.err   = req_i.valid & bad_access;
    assign rsp_o.rdata = (req_i.valid & ~req_i.write & ~bad_access) ?
                         {{PAD_W{1'b0}}, rd_val} : '0;

    assign wr_en = req_i.valid & req_i.write & ~bad_access;

    ////////////////////////////////////////////////////////////
    // Input path
    ////////////////////////////////////////////////////////////

    // Two flops before IN, then one more for the edge reference
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;
        end else begin
            sync1_q <= pin_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
        end
    end

    assign rise = sync2_q & ~prev_q;

    ////////////////////////////////////////////////////////////
    // Control and status registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dir_q    <= '0;
            out_q    <= '0;
            irqen_q  <= '0;
            status_q <= '0;
        end else begin
            if (wr_en && req_i.offset == `GPIO_REG_DIR) begin
                dir_q <= req_i.wdata[`GPIO_BANK_W-1:0];
            end
            if (wr_en && req_i.offset == `GPIO_REG_OUT) begin
                out_q <= req_i.wdata[`GPIO_BANK_W-1:0];
            end
            if (wr_en && req_i.offset == `GPIO_REG_IRQEN) begin
                irqen_q <= req_i.wdata[`GPIO_BANK_W-1:0];
            end
            // New edges take priority over a clear in the same cycle
            if (wr_en && req_i.offset == `GPIO_REG_STATUS) begin
                status_q <= (status_q & ~req_i.wdata[`GPIO_BANK_W-1:0]) | (rise & irqen_q);
            end else begin
                status_q <= status_q | (rise & irqen_q);
            end
        end
    end

    assign pin_o = out_q;
    assign dir_o = dir_q;
    assign irq_o = |status_q;

endmodule

// File: logic/periph_resp_merge.sv
`include "soc_gpio_cfg.svh"

module periph_resp_merge (
    input  soc_periph_pkg::reg_rsp_t [`GPIO_NBANK-1:0] bank_rsp_i,
    input  logic [`GPIO_NBANK-1:0]                     bank_irq_i,
    output soc_periph_pkg::reg_rsp_t                   rsp_o,
    output logic [`FC_EVT_W-1:0]                       fc_events_o
);

    import soc_periph_pkg::*;

    reg_rsp_t               rsp_acc;
    logic [`FC_EVT_W-1:0]   evt_vec;

    ////////////////////////////////////////////////////////////
    // Response merge
    ////////////////////////////////////////////////////////////

    // Only the addressed bank drives non-zero values
    always_comb begin
        rsp_acc = '0;
        for (int k = 0; k < `GPIO_NBANK; k++) begin
            rsp_acc.rdata = rsp_acc.rdata | bank_rsp_i[k].rdata;
            rsp_acc.err   = rsp_acc.err | bank_rsp_i[k].err;
        end
    end

    assign rsp_o = rsp_acc;

    ////////////////////////////////////////////////////////////
    // Fabric controller event vector
    ////////////////////////////////////////////////////////////

    // Bank k lands on bit GPIO_EVT_POS+k
    // every other slot is reserved and tied low
    always_comb begin
        evt_vec = '0;
        for (int k = 0; k < `GPIO_NBANK; k++) begin
            evt_vec[`GPIO_EVT_POS + k] = bank_irq_i[k];
        end
    end

    assign fc_events_o = evt_vec;

endmodule

// File: logic/soc_gpio_periph.sv
`include "soc_gpio_cfg.svh"

module soc_gpio_periph (
    input  logic                                  clk_i,
    input  logic                                  rst_i,

    input  soc_periph_pkg::axil_aw_t              aw_i,
    input  logic                                  awvalid_i,
    output logic                                  awready_o,
    input  soc_periph_pkg::axil_w_t               w_i,
    input  logic                                  wvalid_i,
    output logic                                  wready_o,
    input  soc_periph_pkg::axil_aw_t              ar_i,
    input  logic                                  arvalid_i,
    output logic                                  arready_o,
    output soc_periph_pkg::axil_b_t               b_o,
    output logic                                  bvalid_o,
    input  logic                                  bready_i,
    output soc_periph_pkg::axil_r_t               r_o,
    output logic                                  rvalid_o,
    input  logic                                  rready_i,

    input  logic [`GPIO_NBANK*`GPIO_BANK_W-1:0]   gpio_in_i,
    output logic [`GPIO_NBANK*`GPIO_BANK_W-1:0]   gpio_out_o,
    output logic [`GPIO_NBANK*`GPIO_BANK_W-1:0]   gpio_dir_o,
    output logic [`FC_EVT_W-1:0]                  fc_events_o
);

    import soc_periph_pkg::*;

    reg_req_t [`GPIO_NBANK-1:0] bank_req;
    reg_rsp_t [`GPIO_NBANK-1:0] bank_rsp;
    reg_rsp_t                   merged_rsp;
    logic [`GPIO_NBANK-1:0]     bank_irq;

    ////////////////////////////////////////////////////////////
    // Register bus front end
    ////////////////////////////////////////////////////////////

    axil_reg_slave i_axil_reg_slave (
        .clk_i      ( clk_i      ),
        .rst_i      ( rst_i      ),
        .aw_i       ( aw_i       ),
        .awvalid_i  ( awvalid_i  ),
        .awready_o  ( awready_o  ),
        .w_i        ( w_i        ),
        .wvalid_i   ( wvalid_i   ),
        .wready_o   ( wready_o   ),
        .ar_i       ( ar_i       ),
        .arvalid_i  ( arvalid_i  ),
        .arready_o  ( arready_o  ),
        .b_o        ( b_o        ),
        .bvalid_o   ( bvalid_o   ),
        .bready_i   ( bready_i   ),
        .r_o        ( r_o        ),
        .rvalid_o   ( rvalid_o   ),
        .rready_i   ( rready_i   ),
        .bank_req_o ( bank_req   ),
        .rsp_i      ( merged_rsp )
    );

    ////////////////////////////////////////////////////////////
    // GPIO banks
    ////////////////////////////////////////////////////////////

    for (genvar k = 0; k < `GPIO_NBANK; k++) begin : g_bank
        gpio_bank i_gpio_bank (
            .clk_i ( clk_i                                    ),
            .rst_i ( rst_i                                    ),
            .req_i ( bank_req[k]                              ),
            .rsp_o ( bank_rsp[k]                              ),
            .pin_i ( gpio_in_i[k*`GPIO_BANK_W +: `GPIO_BANK_W]  ),
            .pin_o ( gpio_out_o[k*`GPIO_BANK_W +: `GPIO_BANK_W] ),
            .dir_o ( gpio_dir_o[k*`GPIO_BANK_W +: `GPIO_BANK_W] ),
            .irq_o ( bank_irq[k]                              )
        );
    end

    periph_resp_merge i_periph_resp_merge (
        .bank_rsp_i  ( bank_rsp    ),
        .bank_irq_i  ( bank_irq    ),
        .rsp_o       ( merged_rsp  ),
        .fc_events_o ( fc_events_o )
    );

endmodule

// File: logic/soc_periph_pkg.sv
`include "soc_gpio_cfg.svh"

package soc_periph_pkg;

    // Offset bits that address a register inside one bank
    localparam int REG_OFF_W = $clog2(`GPIO_BANK_STRIDE);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef struct packed {
        logic [`AXI_ADDR_W-1:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic [`AXI_DATA_W-1:0]   data;
        logic [`AXI_DATA_W/8-1:0] strb;
    } axil_w_t;

    typedef struct packed {
        logic [`AXI_DATA_W-1:0] data;
        logic [1:0]             resp;
    } axil_r_t;

    typedef struct packed {
        logic [1:0] resp;
    } axil_b_t;

    // One register access towards one bank
    typedef struct packed {
        logic                   valid;
        logic                   write;
        logic [REG_OFF_W-1:0]   offset;
        logic [`AXI_DATA_W-1:0] wdata;
    } reg_req_t;

    // All zero when the bank is not addressed
    typedef struct packed {
        logic [`AXI_DATA_W-1:0] rdata;
        logic                   err;
    } reg_rsp_t;

endpackage

// File: soc_gpio_cfg.svh
`ifndef SOC_GPIO_CFG_SVH
`define SOC_GPIO_CFG_SVH

// Bank geometry
`define GPIO_NBANK        4
`define GPIO_BANK_W       8
`define GPIO_BANK_STRIDE  32

// Register offsets inside one bank
`define GPIO_REG_DIR      5'h00
`define GPIO_REG_OUT      5'h04
`define GPIO_REG_IN       5'h08
`define GPIO_REG_IRQEN    5'h0C
`define GPIO_REG_STATUS   5'h10

// Event vector and bus widths
`define GPIO_EVT_POS      15
`define FC_EVT_W          32
`define AXI_DATA_W        32
`define AXI_ADDR_W        12

`endif

// File: soc_gpio_periph.f
+incdir+.
logic/soc_periph_pkg.sv
logic/axil_reg_slave.sv
logic/gpio_bank.sv
logic/periph_resp_merge.sv
logic/soc_gpio_periph.sv
verif/soc_gpio_periph_checker.sv
verif/tb_soc_gpio_periph.sv

// File: verif/soc_gpio_periph_checker.sv
module soc_gpio_periph_checker (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  soc_periph_pkg::axil_b_t  b_i,
    input  logic                     bvalid_i,
    input  logic                     bready_i,
    input  soc_periph_pkg::axil_r_t  r_i,
    input  logic                     rvalid_i,
    input  logic                     rready_i,
    input  logic                     awready_i,
    input  logic                     arready_i
);

    // Valid stays up until the master takes the response
    a_b_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        bvalid_i && !bready_i |=> bvalid_i) else $error("bvalid dropped before bready");
    a_r_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        rvalid_i && !rready_i |=> rvalid_i) else $error("rvalid dropped before rready");

    // Payload frozen while waiting
    a_b_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        bvalid_i && !bready_i |=> $stable(b_i)) else $error("B payload changed while valid");
    a_r_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        rvalid_i && !rready_i |=> $stable(r_i)) else $error("R payload changed while valid");

    // No new address while a response is outstanding
    a_no_accept: assert property (@(posedge clk_i) disable iff (rst_i)
        (bvalid_i || rvalid_i) |-> !awready_i && !arready_i)
        else $error("address ready while a response is pending");

endmodule

// File: verif/tb_soc_gpio_periph.sv
`include "soc_gpio_cfg.svh"

module tb_soc_gpio_periph;

    import soc_periph_pkg::*;

    typedef enum logic [2:0] {OP_WR, OP_RD, OP_PIN, OP_WRND, OP_RDM} op_e;

    typedef struct packed {
        op_e         op;
        logic [11:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
        logic [1:0]  resp;
        logic [31:0] evt;
        int          hold;
    } entry_t;

    logic clk_i;
    logic rst_i;
    axil_aw_t aw;
    axil_w_t w;
    axil_aw_t ar;
    axil_b_t b;
    axil_r_t r;
    logic awvalid, awready, wvalid, wready, arvalid, arready;
    logic bvalid, bready, rvalid, rready;
    logic [31:0] gpio_in, gpio_out, gpio_dir, fc_events;

    entry_t tbl[$];
    logic [7:0] dir_m[4];
    logic [7:0] out_m[4];
    logic [31:0] lfsr_state;
    int cycles;
    int limit = 100000;

    soc_gpio_periph dut0 (
        .clk_i(clk_i), .rst_i(rst_i),
        .aw_i(aw), .awvalid_i(awvalid), .awready_o(awready),
        .w_i(w), .wvalid_i(wvalid), .wready_o(wready),
        .ar_i(ar), .arvalid_i(arvalid), .arready_o(arready),
        .b_o(b), .bvalid_o(bvalid), .bready_i(bready),
        .r_o(r), .rvalid_o(rvalid), .rready_i(rready),
        .gpio_in_i(gpio_in), .gpio_out_o(gpio_out), .gpio_dir_o(gpio_dir),
        .fc_events_o(fc_events)
    );

    bind soc_gpio_periph soc_gpio_periph_checker chk0 (
        .clk_i(clk_i), .rst_i(rst_i), .b_i(b_o), .bvalid_i(bvalid_o), .bready_i(bready_i),
        .r_i(r_o), .rvalid_i(rvalid_o), .rready_i(rready_i),
        .awready_i(awready_o), .arready_i(arready_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: no progress after %0d cycles", limit);
            $display("TESTBENCH FAILED");
            $fatal(1, "run aborted");
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    // Galois form, taps x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rnd_byte(output logic [7:0] v);
        for (int i = 0; i < 8; i++) begin
            v[i] = lfsr_state[0];
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic void push_entry(op_e op, logic [11:0] addr, logic [31:0] data,
                                       logic [31:0] exp, logic [1:0] resp,
                                       logic [31:0] evt, int hold);
        entry_t e;
        e.op   = op;
        e.addr = addr;
        e.data = data;
        e.exp  = exp;
        e.resp = resp;
        e.evt  = evt;
        e.hold = hold;
        tbl.push_back(e);
    endfunction

    // One AXI4-Lite access, response held back for hold cycles
    task automatic bus_access(input logic is_wr, input logic [11:0] addr,
                              input logic [31:0] data, input int hold,
                              output logic [31:0] rdata, output logic [1:0] resp);
        logic [31:0] snap_data;
        logic [1:0]  snap_resp;
        @(posedge clk_i);
        #2;
        if (is_wr) begin
            aw.addr = addr;
            w.data  = data;
            w.strb  = '1;
            awvalid = 1'b1;
            wvalid  = 1'b1;
        end else begin
            ar.addr = addr;
            arvalid = 1'b1;
        end
        @(negedge clk_i);
        while (!(is_wr ? awready : arready)) @(negedge clk_i);
        if (is_wr) begin
            check_val("wready_o", wready, 1);
        end
        @(posedge clk_i);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        arvalid = 1'b0;
        @(negedge clk_i);
        while (!(is_wr ? bvalid : rvalid)) @(negedge clk_i);
        snap_data = is_wr ? 32'h0 : r.data;
        snap_resp = is_wr ? b.resp : r.resp;
        // Another request offered during the stall must not be taken
        repeat (hold) begin
            @(posedge clk_i);
            #2;
            awvalid = is_wr;
            wvalid  = is_wr;
            arvalid = !is_wr;
            @(negedge clk_i);
            check_val(is_wr ? "bvalid_o" : "rvalid_o", is_wr ? bvalid : rvalid, 1);
            check_val(is_wr ? "b_o.resp" : "r_o.resp", is_wr ? b.resp : r.resp, snap_resp);
            if (!is_wr) begin
                check_val("r_o.data", r.data, snap_data);
            end
            check_val("awready_o", awready, 0);
            check_val("wready_o", wready, 0);
            check_val("arready_o", arready, 0);
        end
        @(posedge clk_i);
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        arvalid = 1'b0;
        bready  = is_wr;
        rready  = !is_wr;
        @(posedge clk_i);
        #2;
        bready = 1'b0;
        rready = 1'b0;
        rdata = snap_data;
        resp  = snap_resp;
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////

    task automatic build_table();
        logic [31:0] pins;
        pins = 32'ha53c_0f81;
        for (int k = 0; k < 4; k++) begin
            push_entry(OP_RD, k*32 + 12'h00, 0, 0, RESP_OKAY, 0, 0);
            push_entry(OP_RD, k*32 + 12'h04, 0, 0, RESP_OKAY, 0, 0);
            push_entry(OP_RD, k*32 + 12'h0C, 0, 0, RESP_OKAY, 0, 0);
            push_entry(OP_RD, k*32 + 12'h10, 0, 0, RESP_OKAY, 0, 0);
        end
        for (int k = 0; k < 4; k++) begin
            push_entry(OP_WRND, k*32 + 12'h00, 0, 0, RESP_OKAY, 0, 0);
            push_entry(OP_WRND, k*32 + 12'h04, 0, 0, RESP_OKAY, 0, 0);
            push_entry(OP_RDM, k*32 + 12'h00, 0, 0, RESP_OKAY, 0, 0);
            push_entry(OP_RDM, k*32 + 12'h04, 0, 0, RESP_OKAY, 0, 0);
        end
        push_entry(OP_PIN, 0, pins, 0, RESP_OKAY, 0, 0);
        for (int k = 0; k < 4; k++) begin
            push_entry(OP_RD, k*32 + 12'h08, 0, (pins >> (8*k)) & 32'hff, RESP_OKAY, 0, 0);
        end
        // Interrupts on bank 0 low nibble and bank 2 high nibble
        push_entry(OP_WR, 12'h00C, 32'h0F, 0, RESP_OKAY, 0, 0);
        push_entry(OP_WR, 12'h04C, 32'hF0, 0, RESP_OKAY, 0, 0);
        push_entry(OP_PIN, 0, 32'h0, 0, RESP_OKAY, 0, 0);
        push_entry(OP_PIN, 0, 32'hffff_ffff, 0, RESP_OKAY, 32'h0002_8000, 0);
        push_entry(OP_RD, 12'h010, 0, 32'h0F, RESP_OKAY, 32'h0002_8000, 0);
        push_entry(OP_RD, 12'h030, 0, 32'h00, RESP_OKAY, 32'h0002_8000, 0);
        push_entry(OP_RD, 12'h050, 0, 32'hF0, RESP_OKAY, 32'h0002_8000, 0);
        push_entry(OP_WR, 12'h010, 32'h03, 0, RESP_OKAY, 32'h0002_8000, 0);
        push_entry(OP_RD, 12'h010, 0, 32'h0C, RESP_OKAY, 32'h0002_8000, 0);
        push_entry(OP_WR, 12'h010, 32'hFF, 0, RESP_OKAY, 32'h0002_0000, 0);
        push_entry(OP_WR, 12'h050, 32'hF0, 0, RESP_OKAY, 0, 0);
        push_entry(OP_RD, 12'h050, 0, 32'h00, RESP_OKAY, 0, 0);
        // Error paths leave every register alone
        push_entry(OP_RD, 12'h080, 0, 0, RESP_SLVERR, 0, 3);
        push_entry(OP_RD, 12'h0FC, 0, 0, RESP_SLVERR, 0, 0);
        push_entry(OP_RD, 12'h014, 0, 0, RESP_SLVERR, 0, 0);
        push_entry(OP_WR, 12'h028, 32'h00, 0, RESP_SLVERR, 0, 0);
        push_entry(OP_RD, 12'h028, 0, 32'hFF, RESP_OKAY, 0, 0);
        // Aliases onto OUT of bank 0 if the range check were missing
        push_entry(OP_WR, 12'h084, 32'hAA, 0, RESP_SLVERR, 0, 0);
        push_entry(OP_WR, 12'h018, 32'h55, 0, RESP_SLVERR, 0, 0);
        push_entry(OP_RDM, 12'h000, 0, 0, RESP_OKAY, 0, 0);
        // Back-pressure on both response channels
        push_entry(OP_RDM, 12'h024, 0, 0, RESP_OKAY, 0, 5);
        push_entry(OP_WR, 12'h06C, 32'h00, 0, RESP_OKAY, 0, 4);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        entry_t e;
        logic [31:0] got;
        logic [1:0] resp;
        logic [7:0] v;
        int bk;
        rst_i = 1'b1;
        aw = '0;
        w = '0;
        ar = '0;
        {awvalid, wvalid, arvalid, bready, rready} = '0;
        gpio_in = '0;
        cycles = 0;
        lfsr_state = 32'h22fc;
        for (int k = 0; k < 4; k++) begin
            dir_m[k] = '0;
            out_m[k] = '0;
        end
        build_table();
        limit = 30 * tbl.size() + 100;
        repeat (3) @(posedge clk_i);
        #2;
        rst_i = 1'b0;
        // Idle state right after reset
        @(negedge clk_i);
        check_val("awready_o", awready, 0);
        check_val("wready_o", wready, 0);
        check_val("arready_o", arready, 0);
        check_val("bvalid_o", bvalid, 0);
        check_val("rvalid_o", rvalid, 0);
        check_val("fc_events_o", fc_events, 0);
        foreach (tbl[i]) begin
            e = tbl[i];
            bk = e.addr[6:5];
            case (e.op)
                OP_PIN: begin
                    @(posedge clk_i);
                    #2;
                    gpio_in = e.data;
                    repeat (5) @(posedge clk_i);
                end
                OP_WR: begin
                    bus_access(1'b1, e.addr, e.data, e.hold, got, resp);
                    check_val("bresp", resp, e.resp);
                end
                OP_RD: begin
                    bus_access(1'b0, e.addr, 0, e.hold, got, resp);
                    check_val("rdata", got, e.exp);
                    check_val("rresp", resp, e.resp);
                end
                OP_WRND: begin
                    rnd_byte(v);
                    bus_access(1'b1, e.addr, {24'h0, v}, e.hold, got, resp);
                    check_val("bresp", resp, e.resp);
                    if (e.addr[4:0] == 5'h00) begin
                        dir_m[bk] = v;
                    end else begin
                        out_m[bk] = v;
                    end
                end
                default: begin
                    bus_access(1'b0, e.addr, 0, e.hold, got, resp);
                    check_val("rdata", got, e.addr[4:0] == 5'h00 ? dir_m[bk] : out_m[bk]);
                    check_val("rresp", resp, e.resp);
                end
            endcase
            @(negedge clk_i);
            check_val("fc_events_o", fc_events, e.evt);
            check_val("gpio_dir_o", gpio_dir, {dir_m[3], dir_m[2], dir_m[1], dir_m[0]});
            check_val("gpio_out_o", gpio_out, {out_m[3], out_m[2], out_m[1], out_m[0]});
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
